//--- logic/core_settings.svh
// Core build settings
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path and address width
`define CORE_XLEN 32

// Integer register count, x0 included
`define CORE_NREGS 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// Entries in the instruction queue between fetch and execute
`define CORE_FIFO_DEPTH 4

`endif

//--- logic/core_pkg.sv
// Core shared types
`default_nettype none
`include "core_settings.svh"

package core_pkg;

  // Major opcodes this core executes
  // Everything else ends in the halt state
  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // Register-register ALU
    OP_IMM = 7'b0010011,  // Register-immediate ALU
    LUI    = 7'b0110111,  // Load upper immediate
    AUIPC  = 7'b0010111   // Add upper immediate to PC
  } opcode_e;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,     // Signed compare
    ALU_SLTU,    // Unsigned compare
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,     // Arithmetic right shift
    ALU_OR,
    ALU_AND,
    ALU_PASS_B   // Operand b straight through for LUI
  } alu_op_e;

  // One fetched instruction with its own address
  // AUIPC needs the pc long after fetch has moved on
  typedef struct packed {
    logic [`CORE_XLEN-1:0] pc;     // Address the word came from
    logic [31:0]           instr;  // Raw instruction word
  } fetch_item_t;

endpackage

`default_nettype wire

//--- logic/instr_stream_if.sv
// Instruction stream link
`timescale 1ns/1ps
`default_nettype none

interface instr_stream_if (
  input logic clk
);

  logic                  valid;  // Source has an item
  logic                  ready;  // Sink can take it
  core_pkg::fetch_item_t item;   // Fetched word and its pc

  modport source (input clk, output valid, output item, input ready);
  modport sink   (input clk, input valid, input item, output ready);

  // A stalled item stays offered and unchanged until taken
  // Holds across both ends of every link
  stall_hold_a: assert property (@(posedge clk)
    (valid && !ready) |=> (valid && $stable(item)));

endinterface

`default_nettype wire

//--- logic/alu_unit.sv
// Integer ALU
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module alu_unit (
  input  core_pkg::alu_op_e     op,
  input  logic [`CORE_XLEN-1:0] a,
  input  logic [`CORE_XLEN-1:0] b,
  output logic [`CORE_XLEN-1:0] y
);

  logic [4:0] shamt;  // Shift amount from the low bits of b only

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      core_pkg::ALU_ADD:    y = a + b;
      core_pkg::ALU_SUB:    y = a - b;
      core_pkg::ALU_SLL:    y = a << shamt;
      core_pkg::ALU_SLT:    y = `CORE_XLEN'($signed(a) < $signed(b));
      core_pkg::ALU_SLTU:   y = `CORE_XLEN'(a < b);
      core_pkg::ALU_XOR:    y = a ^ b;
      core_pkg::ALU_SRL:    y = a >> shamt;
      core_pkg::ALU_SRA:    y = $unsigned($signed(a) >>> shamt);  // Sign fill
      core_pkg::ALU_OR:     y = a | b;
      core_pkg::ALU_AND:    y = a & b;
      core_pkg::ALU_PASS_B: y = b;  // LUI value
      default:              y = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  output logic                  imem_req,
  output logic [`CORE_XLEN-1:0] imem_addr,
  input  logic                  imem_ack,
  input  logic [`CORE_XLEN-1:0] imem_rdata,
  instr_stream_if.source        out
);

  // Four-phase handshake sequence
  typedef enum logic [1:0] {
    F_IDLE,      // Nothing outstanding
    F_WAIT_ACK,  // req up while memory works
    F_WAIT_LOW   // Word taken and ack must drop first
  } fetch_state_e;

  fetch_state_e          state;
  logic [`CORE_XLEN-1:0] pc;          // Address of the next fetch
  logic                  hold_valid;  // Holding register occupied
  core_pkg::fetch_item_t hold_item;   // Word waiting for the queue
  logic                  capture;     // Memory answered this cycle
  logic                  drain;       // Queue takes the held word

  assign capture = (state == F_WAIT_ACK) && imem_ack;
  assign drain   = hold_valid && out.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= F_IDLE;
      pc         <= `CORE_RESET_PC;
      hold_valid <= 1'b0;
    end else begin
      case (state)
        F_IDLE: begin
          if (!hold_valid) begin  // Only fetch with room to keep the word
            state <= F_WAIT_ACK;
          end
        end
        F_WAIT_ACK: begin
          if (imem_ack) begin
            state <= F_WAIT_LOW;       // req drops with the capture
            pc    <= pc + `CORE_XLEN'(4);  // Always the next word since nothing jumps
          end
        end
        F_WAIT_LOW: begin
          if (!imem_ack) begin
            state <= F_IDLE;
          end
        end
        default: state <= F_IDLE;
      endcase
      if (capture) begin
        hold_valid <= 1'b1;
      end else if (drain) begin
        hold_valid <= 1'b0;
      end
    end
  end

  // Payload only meaningful while hold_valid is set
  always_ff @(posedge clk) begin
    if (capture) begin
      hold_item.pc    <= pc;
      hold_item.instr <= imem_rdata;
    end
  end

  assign imem_req  = (state == F_WAIT_ACK);
  assign imem_addr = pc;
  assign out.valid = hold_valid;
  assign out.item  = hold_item;

  // Address holds for the whole request and req waits for ack
  addr_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    (imem_req && !imem_ack) |=> (imem_req && $stable(imem_addr)));
  // New request only after the previous ack has gone low
  req_after_ack_low_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(imem_req) |-> !imem_ack);

endmodule

`default_nettype wire

//--- logic/instr_fifo.sv
// Instruction queue
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module instr_fifo (
  input logic          clk,
  input logic          rst_n,
  instr_stream_if.sink in,
  instr_stream_if.source out
);

  localparam int DEPTH = `CORE_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);      // Pointer width
  localparam int CW    = $clog2(DEPTH + 1);  // Count reaches DEPTH

  core_pkg::fetch_item_t mem [DEPTH];  // Queue entries
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic [CW-1:0]         count;
  logic                  push;
  logic                  pop;

  assign in.ready  = (count != CW'(DEPTH));  // Back-pressure when full
  assign out.valid = (count != '0);
  assign out.item  = mem[rd_ptr];            // Head of queue

  assign push = in.valid && in.ready;
  assign pop  = out.valid && out.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
      end
      count <= count + CW'(push) - CW'(pop);  // Both at once leaves it alone
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in.item;
    end
  end

  // Fetch never overruns and execute never reads ahead of the queue
  no_overflow_a: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count < CW'(DEPTH)));
  no_underflow_a: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> (count > '0));

endmodule

`default_nettype wire

//--- logic/execute_unit.sv
// Decode and execute stage
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module execute_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  instr_stream_if.sink          in,
  output logic                  retire_valid,
  output logic [4:0]            retire_rd,
  output logic [`CORE_XLEN-1:0] retire_value,
  output logic                  halted
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];  // x0 slot never written
  logic [31:0]           instr;
  logic [4:0]            rs1, rs2, rd;
  logic [2:0]            funct3;
  logic                  alt_sel;     // Bit 30 where it means SUB or SRA
  logic [`CORE_XLEN-1:0] rs1_val, rs2_val;
  logic [`CORE_XLEN-1:0] imm_i, imm_u;
  logic                  legal;       // Opcode this core implements
  core_pkg::alu_op_e     alu_op;
  logic [`CORE_XLEN-1:0] op_a, op_b, alu_y;
  logic                  accept;

  // funct3 table shared by OP and OP_IMM
  function automatic core_pkg::alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
    core_pkg::alu_op_e res;
    case (f3)
      3'b000:  res = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      3'b001:  res = core_pkg::ALU_SLL;
      3'b010:  res = core_pkg::ALU_SLT;
      3'b011:  res = core_pkg::ALU_SLTU;
      3'b100:  res = core_pkg::ALU_XOR;
      3'b101:  res = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      3'b110:  res = core_pkg::ALU_OR;
      default: res = core_pkg::ALU_AND;
    endcase
    return res;
  endfunction

  assign instr  = in.item.instr;
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign imm_i  = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};  // Sign-extended
  assign imm_u  = {instr[31:12], 12'b0};
  // Bit 30 of ADDI belongs to the immediate
  assign alt_sel = instr[30] && ((instr[6:0] == core_pkg::OP) || (funct3 == 3'b101));

  assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];  // x0 reads zero
  assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

  // Operand and operation select per opcode
  always_comb begin
    legal  = 1'b1;
    alu_op = f3_to_alu(funct3, alt_sel);
    op_a   = rs1_val;
    op_b   = rs2_val;
    case (instr[6:0])
      core_pkg::OP: begin
      end
      core_pkg::OP_IMM: op_b = imm_i;  // Shifts take shamt from the low bits
      core_pkg::LUI: begin
        alu_op = core_pkg::ALU_PASS_B;
        op_b   = imm_u;
      end
      core_pkg::AUIPC: begin
        alu_op = core_pkg::ALU_ADD;
        op_a   = in.item.pc;  // Address of this instruction
        op_b   = imm_u;
      end
      default: legal = 1'b0;  // Loads, stores, jumps and system all halt
    endcase
  end

  alu_unit alu_i (.op(alu_op), .a(op_a), .b(op_b), .y(alu_y));

  assign in.ready = !halted;
  assign accept   = in.valid && in.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
      halted       <= 1'b0;
    end else begin
      retire_valid <= accept && legal;         // One-cycle pulse
      if (accept && !legal) begin
        halted <= 1'b1;  // Sticky until reset
      end
    end
  end

  // Register write and retire payload
  always_ff @(posedge clk) begin
    if (accept && legal) begin
      retire_rd    <= rd;
      retire_value <= alu_y;  // Reported even for rd = x0
      if (rd != 5'd0) begin
        regs[rd] <= alu_y;
      end
    end
  end

  // Nothing retires once the core has stopped
  halt_quiet_a: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !retire_valid);

endmodule

`default_nettype wire

//--- logic/rv_core_top.sv
// RV32I core top level
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module rv_core_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // Instruction memory with four-phase req/ack
  output logic                  imem_req,
  output logic [`CORE_XLEN-1:0] imem_addr,
  input  logic                  imem_ack,
  input  logic [`CORE_XLEN-1:0] imem_rdata,
  // Retirement report without back-pressure
  output logic                  retire_valid,
  output logic [4:0]            retire_rd,
  output logic [`CORE_XLEN-1:0] retire_value,
  output logic                  halted
);

  instr_stream_if fetch_to_fifo (.clk(clk));  // Fetch into queue
  instr_stream_if fifo_to_exec (.clk(clk));   // Queue into execute

  fetch_unit fetch_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_ack   (imem_ack),
    .imem_rdata (imem_rdata),
    .out        (fetch_to_fifo.source)
  );

  instr_fifo fifo_i (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (fetch_to_fifo.sink),
    .out   (fifo_to_exec.source)
  );

  execute_unit exec_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in           (fifo_to_exec.sink),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_value (retire_value),
    .halted       (halted)
  );

endmodule

`default_nettype wire

//--- verif/tb_core.sv
// Core testbench
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module tb_core;

  localparam int PROG_LEN    = 200;   // Random instructions before the halt word
  localparam int REQ_TIMEOUT = 1000;  // Idle cycles tolerated between fetches
  localparam int ACK_TIMEOUT = 20;
  localparam int RET_TIMEOUT = 100;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  imem_req;
  logic [`CORE_XLEN-1:0] imem_addr;
  logic                  imem_ack;
  logic [`CORE_XLEN-1:0] imem_rdata;
  logic                  retire_valid;
  logic [4:0]            retire_rd;
  logic [`CORE_XLEN-1:0] retire_value;
  logic                  halted;

  int          seed       = 60931;
  int          mismatches = 0;
  int          failures   = 0;  // Timeouts and protocol trouble
  int          retired    = 0;
  logic [31:0] prog [PROG_LEN + 1];       // Program plus the halt word
  logic [4:0]  exp_rd [PROG_LEN];
  logic [31:0] exp_val [PROG_LEN];
  logic [31:0] model_regs [`CORE_NREGS];  // Reference registers, x0 never written

  always #4 clk = ~clk;  // 8 ns period

  rv_core_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .imem_ack     (imem_ack),
    .imem_rdata   (imem_rdata),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_value (retire_value),
    .halted       (halted)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      mismatches++;
    end
  endtask

  // Result of one instruction under the RV32I rules
  function automatic logic [31:0] predict(input logic [31:0] ins, input logic [31:0] pc);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        is_op;
    is_op = (ins[6:0] == core_pkg::OP);
    a     = model_regs[ins[19:15]];
    b     = is_op ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    case (ins[14:12])
      3'b000:  res = (is_op && ins[30]) ? a - b : a + b;  // ADDI has no SUB form
      3'b001:  res = a << b[4:0];
      3'b010:  res = {31'b0, $signed(a) < $signed(b)};
      3'b011:  res = {31'b0, a < b};  // Negative imm compares as huge
      3'b100:  res = a ^ b;
      3'b101: begin
        if (ins[30]) begin
          res = $unsigned($signed(a) >>> b[4:0]);
        end else begin
          res = a >> b[4:0];
        end
      end
      3'b110:  res = a | b;
      default: res = a & b;
    endcase
    if (ins[6:0] == core_pkg::LUI) begin
      res = {ins[31:12], 12'b0};
    end
    if (ins[6:0] == core_pkg::AUIPC) begin
      res = pc + {ins[31:12], 12'b0};
    end
    return res;
  endfunction

  // Random program and the retirements it should produce
  task automatic build_program();
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    for (int k = 0; k < `CORE_NREGS; k++) begin
      model_regs[k] = 32'h0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      r  = $random(seed);
      s  = $random(seed);
      rd = (s[2:0] == 3'd0) ? 5'd0 : s[7:3];  // x0 destination now and then
      f3 = r[14:12];
      if (i < `CORE_NREGS - 1) begin
        rd = 5'(i + 1);  // Seed every register before it is read
        if (r[0]) begin
          prog[i] = {r[31:12], rd, core_pkg::LUI};
        end else begin
          prog[i] = {r[31:20], 5'd0, 3'b000, rd, core_pkg::OP_IMM};
        end
      end else begin
        case (s[31:29])
          3'd0, 3'd1, 3'd2: begin
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[30]) ? 7'h20 : 7'h00;
            prog[i] = {f7, s[17:13], s[12:8], f3, rd, core_pkg::OP};
          end
          3'd6:    prog[i] = {r[31:12], rd, core_pkg::LUI};
          3'd7:    prog[i] = {r[31:12], rd, core_pkg::AUIPC};
          default: begin
            imm = r[31:20];
            if (f3 == 3'b001) begin
              imm[11:5] = 7'h00;  // SLLI
            end
            if (f3 == 3'b101) begin
              imm[11:5] = r[29] ? 7'h20 : 7'h00;  // SRAI or SRLI
            end
            prog[i] = {imm, s[12:8], f3, rd, core_pkg::OP_IMM};
          end
        endcase
      end
      exp_rd[i]  = rd;
      exp_val[i] = predict(prog[i], `CORE_RESET_PC + 32'(4 * i));
      if (rd != 5'd0) begin
        model_regs[rd] = exp_val[i];
      end
    end
    r = $random(seed);
    prog[PROG_LEN] = {r[31:7], 7'b0000000};  // Unimplemented opcode
  endtask

  task automatic wait_retire(output logic got);
    got = 1'b0;
    for (int waited = 0; waited < RET_TIMEOUT; waited++) begin
      @(posedge clk);
      if (retire_valid === 1'b1) begin
        got = 1'b1;
        retired++;
        return;
      end
      if (halted === 1'b1) begin
        $display("ERROR: core halted after only %0d retirements", retired);
        failures++;
        return;
      end
    end
    $display("ERROR: no retirement within %0d cycles after %0d retirements",
             RET_TIMEOUT, retired);
    failures++;
  endtask

  // Instruction memory answering four-phase req/ack after random phase delays
  initial begin : imem_model
    int n;
    int delay;
    int waited;
    n          = 0;
    imem_ack   = 1'b0;
    imem_rdata = '0;
    repeat (3) @(posedge clk);
    forever begin
      waited = 0;
      while (imem_req !== 1'b1 && waited < REQ_TIMEOUT) begin
        @(posedge clk);
        waited++;
      end
      if (imem_req !== 1'b1) begin
        $display("ERROR: no fetch request for %0d cycles", REQ_TIMEOUT);
        failures++;
        break;
      end
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) @(posedge clk);
      check_value($sformatf("imem_addr fetch %0d", n),
                  `CORE_RESET_PC + 32'(4 * n), imem_addr);
      imem_ack   <= 1'b1;
      // Past the end each word holds its own address
      imem_rdata <= (n <= PROG_LEN) ? prog[n] : `CORE_RESET_PC + 32'(4 * n);
      n++;
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
      end while (imem_req === 1'b1 && waited < ACK_TIMEOUT);
      if (imem_req === 1'b1) begin
        $display("ERROR: fetch request still high %0d cycles after ack", ACK_TIMEOUT);
        failures++;
        break;
      end
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) @(posedge clk);
      imem_ack <= 1'b0;
    end
  end

  initial begin : main
    int   waited;
    logic got;
    rst_n = 1'b0;
    build_program();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < PROG_LEN; i++) begin
      wait_retire(got);
      if (!got) begin
        break;
      end
      check_value($sformatf("retire %0d rd", i), {27'b0, exp_rd[i]}, {27'b0, retire_rd});
      check_value($sformatf("retire %0d value", i), exp_val[i], retire_value);
    end
    // Halt word stops the core without retiring
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (retire_valid === 1'b1) begin
        retired++;
      end
    end while (halted !== 1'b1 && waited < RET_TIMEOUT);
    if (halted !== 1'b1) begin
      $display("ERROR: core did not halt within %0d cycles", RET_TIMEOUT);
      failures++;
    end
    repeat (50) begin
      @(posedge clk);
      if (retire_valid === 1'b1) begin
        retired++;
      end
      check_value("retire_valid after halt", 32'h0, {31'b0, retire_valid});
      check_value("halted held", 32'h1, {31'b0, halted});
    end
    check_value("retire count", 32'(PROG_LEN), 32'(retired));
    $display("Done: %0d mismatches, %0d other errors, %0d retirements",
             mismatches, failures, retired);
    if (mismatches == 0 && failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+logic
logic/core_pkg.sv
logic/instr_stream_if.sv
logic/alu_unit.sv
logic/fetch_unit.sv
logic/instr_fifo.sv
logic/execute_unit.sv
logic/rv_core_top.sv
verif/tb_core.sv

//--- Makefile
BIN  := obj_dir/Vtb_core
SRCS := $(shell grep -v '^+' compile.f) logic/core_settings.svh

.PHONY: run clean

run: $(BIN)
	$(BIN) > sim.log 2>&1 || echo "Some tests failed" >> sim.log
	@cat sim.log
	@! grep -q "Some tests failed" sim.log

$(BIN): compile.f $(SRCS)
	verilator --binary --timing --assert -f compile.f --top-module tb_core -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log
